// File: vlog.f
rtl/usb_ep_pkg.sv
rtl/usb_hs_pkg.sv
rtl/usb_ep_halt_regs.sv
rtl/usb_ep_space_counter.sv
rtl/usb_ping_fsm.sv
rtl/usb_hs_encoder.sv
rtl/usb_ping_top.sv
tb/usb_ping_checker.sv
tb/usb_ping_chk.sv
tb/usb_ping_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run; pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module usb_ping_tb \
    -f vlog.f -o usb_ping_sim \
    && ./obj_dir/usb_ping_sim | tee /dev/stderr | grep -q "Regression passed" \
    && exit 0 \
    || exit 1

// File: tb/usb_ping_tb.sv
// testbench top for the PING block: clock, reset, directed and random stimulus, summary
module usb_ping_tb
    import usb_ep_pkg::*;
    import usb_hs_pkg::*;
;

    logic        clk_i;
    logic        rst_n_i;
    logic        ping_i;
    ep_num_t     ping_ep_i;
    logic        halt_set_i;
    logic        halt_clr_i;
    ep_num_t     halt_ep_i;
    logic        wr_i;
    ep_num_t     wr_ep_i;
    byte_cnt_t   wr_len_i;
    logic        drain_i;
    ep_num_t     drain_ep_i;
    byte_cnt_t   drain_len_i;
    logic        hs_valid_o;
    logic [7:0]  hs_pid_o;
    logic        busy_o;
    ping_state_e ping_state_o;

    int seed = 32'hd801_25b2;

    usb_ping_top #(
        .NUM_EP    (16),
        .BUF_BYTES (512),
        .MAX_PKT   (512)
    ) u_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ping_i       (ping_i),
        .ping_ep_i    (ping_ep_i),
        .halt_set_i   (halt_set_i),
        .halt_clr_i   (halt_clr_i),
        .halt_ep_i    (halt_ep_i),
        .wr_i         (wr_i),
        .wr_ep_i      (wr_ep_i),
        .wr_len_i     (wr_len_i),
        .drain_i      (drain_i),
        .drain_ep_i   (drain_ep_i),
        .drain_len_i  (drain_len_i),
        .hs_valid_o   (hs_valid_o),
        .hs_pid_o     (hs_pid_o),
        .busy_o       (busy_o),
        .ping_state_o (ping_state_o)
    );

    usb_ping_checker u_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ping_i      (ping_i),
        .ping_ep_i   (ping_ep_i),
        .halt_set_i  (halt_set_i),
        .halt_clr_i  (halt_clr_i),
        .halt_ep_i   (halt_ep_i),
        .wr_i        (wr_i),
        .wr_ep_i     (wr_ep_i),
        .wr_len_i    (wr_len_i),
        .drain_i     (drain_i),
        .drain_ep_i  (drain_ep_i),
        .drain_len_i (drain_len_i),
        .hs_valid_o  (hs_valid_o),
        .hs_pid_o    (hs_pid_o),
        .busy_o      (busy_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk_i);
        while (busy_o) begin
            n++;
            if (n > 20) begin
                abort_run("DUT stayed busy");
            end
            @(posedge clk_i);
        end
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        while (!hs_valid_o) begin
            n++;
            if (n > 10) begin
                abort_run("no handshake after ping");
            end
            @(posedge clk_i);
        end
    endtask

    task automatic ping_ep(input int ep);
        @(posedge clk_i);
        ping_i    <= 1'b1;
        ping_ep_i <= ep_num_t'(ep);
        @(posedge clk_i);
        ping_i <= 1'b0;
        wait_response();
        wait_idle();
    endtask

    task automatic halt_ep(input int ep, input logic set, input logic clr);
        @(posedge clk_i);
        halt_set_i <= set;
        halt_clr_i <= clr;
        halt_ep_i  <= ep_num_t'(ep);
        @(posedge clk_i);
        halt_set_i <= 1'b0;
        halt_clr_i <= 1'b0;
    endtask

    task automatic move_data(input int ep, input int wr_len, input int dr_len);
        @(posedge clk_i);
        wr_i        <= (wr_len > 0);
        wr_ep_i     <= ep_num_t'(ep);
        wr_len_i    <= byte_cnt_t'(wr_len);
        drain_i     <= (dr_len > 0);
        drain_ep_i  <= ep_num_t'(ep);
        drain_len_i <= byte_cnt_t'(dr_len);
        @(posedge clk_i);
        wr_i    <= 1'b0;
        drain_i <= 1'b0;
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        logic [31:0] q;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk_i);
            r = $random(seed);
            q = $random(seed);
            ping_i      <= (r[2:0] == 3'd0);
            ping_ep_i   <= r[7:4];
            halt_set_i  <= (r[11:8] == 4'd0);
            halt_clr_i  <= (r[15:12] == 4'd0);
            halt_ep_i   <= r[19:16];
            wr_i        <= (q[1:0] == 2'd0);
            wr_ep_i     <= r[23:20];
            wr_len_i    <= byte_cnt_t'(q[10:2]);
            drain_i     <= (q[12:11] == 2'd0);
            drain_ep_i  <= r[27:24];
            drain_len_i <= byte_cnt_t'(q[21:13]);
        end
        @(posedge clk_i);
        ping_i     <= 1'b0;
        halt_set_i <= 1'b0;
        halt_clr_i <= 1'b0;
        wr_i       <= 1'b0;
        drain_i    <= 1'b0;
    endtask

    task automatic drain_pending();
        int n;
        n = 0;
        while (u_checker.pending() != 0) begin
            n++;
            if (n > 20) begin
                abort_run("expected responses never arrived");
            end
            @(posedge clk_i);
        end
        wait_idle();
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        ping_i      = 1'b0;
        ping_ep_i   = '0;
        halt_set_i  = 1'b0;
        halt_clr_i  = 1'b0;
        halt_ep_i   = '0;
        wr_i        = 1'b0;
        wr_ep_i     = '0;
        wr_len_i    = '0;
        drain_i     = 1'b0;
        drain_ep_i  = '0;
        drain_len_i = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (3) @(posedge clk_i);

        u_checker.test_name = "reset_ack";
        for (int ep = 0; ep < 16; ep++) begin
            ping_ep(ep);
        end

        u_checker.test_name = "halt";
        halt_ep(5, 1'b1, 1'b0);
        ping_ep(5);
        halt_ep(5, 1'b0, 1'b1);
        ping_ep(5);
        halt_ep(9, 1'b1, 1'b1);
        ping_ep(9);
        halt_ep(9, 1'b0, 1'b1);
        ping_ep(9);

        u_checker.test_name = "space";
        move_data(3, 100, 0);
        ping_ep(3);
        move_data(3, 0, 1000);
        ping_ep(3);
        // a drain past the buffer size must stop at full, so this write leaves too little room
        move_data(3, 100, 0);
        ping_ep(3);
        move_data(3, 2000, 0);
        ping_ep(3);
        move_data(3, 0, 300);
        ping_ep(3);
        move_data(3, 400, 700);
        ping_ep(3);

        // hold ping high across a whole busy window
        u_checker.test_name = "busy_ignore";
        @(posedge clk_i);
        ping_i    <= 1'b1;
        ping_ep_i <= ep_num_t'(3);
        repeat (9) @(posedge clk_i);
        ping_i <= 1'b0;
        drain_pending();

        u_checker.test_name = "random";
        random_traffic(2000);
        drain_pending();
        repeat (4) @(posedge clk_i);

        $display("summary: %0d responses checked, %0d errors",
                 u_checker.resp_cnt, u_checker.err_cnt);
        if (u_checker.err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/usb_ping_chk.sv
// assertions on FSM sequencing, busy flag and handshake pulse width
module usb_ping_chk
    import usb_hs_pkg::*;
(
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        ping_i,
    input ping_state_e ping_state_o,
    input logic        busy_o,
    input logic        hs_valid_o
);

    a_sequence: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ping_state_o == IDLE && ping_i) |=> ping_state_o == LOOKUP ##1
        ping_state_o == DECIDE ##1 ping_state_o == RESPOND ##1 ping_state_o == COMPLETE)
        else $error("ping FSM left the expected state order");

    a_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hs_valid_o |=> !hs_valid_o)
        else $error("handshake valid held for two cycles");

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_o == (ping_state_o != IDLE))
        else $error("busy does not match the FSM state");

endmodule

// the top level holds both the FSM and encoder outputs
bind usb_ping_top usb_ping_chk u_ping_chk (.*);

// File: tb/usb_ping_checker.sv
// response checker with halt and space model, reference function and error counting
module usb_ping_checker
    import usb_ep_pkg::*;
(
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       ping_i,
    input ep_num_t    ping_ep_i,
    input logic       halt_set_i,
    input logic       halt_clr_i,
    input ep_num_t    halt_ep_i,
    input logic       wr_i,
    input ep_num_t    wr_ep_i,
    input byte_cnt_t  wr_len_i,
    input logic       drain_i,
    input ep_num_t    drain_ep_i,
    input byte_cnt_t  drain_len_i,
    input logic       hs_valid_o,
    input logic [7:0] hs_pid_o,
    input logic       busy_o
);

    string      test_name = "reset";
    int         err_cnt   = 0;
    int         resp_cnt  = 0;
    int         cyc       = 0;
    // edges left before the next ping can be taken
    int         block     = 0;
    logic       halt_m [16];
    int         free_m [16];
    logic [7:0] exp_q [$];
    int         due_q [$];

    function automatic logic [7:0] expected_pid(input logic halted, input int free);
        if (halted) begin
            return 8'h1E;
        end
        return (free >= 512) ? 8'hD2 : 8'h5A;
    endfunction

    function automatic int pending();
        return due_q.size();
    endfunction

    always @(posedge clk_i or negedge rst_n_i) begin
        int f;
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                halt_m[i] = 1'b0;
                free_m[i] = 512;
            end
            exp_q.delete();
            due_q.delete();
            block = 0;
        end else begin
            cyc++;
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                if (!hs_valid_o) begin
                    err_cnt++;
                    $display("%s: handshake missing three clocks after the ping", test_name);
                end else begin
                    resp_cnt++;
                    if (hs_pid_o !== exp_q[0]) begin
                        err_cnt++;
                        $display("ERROR %s: expected %h, actual %h",
                                 test_name, exp_q[0], hs_pid_o);
                    end
                end
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end else if (hs_valid_o) begin
                err_cnt++;
                $display("%s: handshake seen with no ping waiting for it", test_name);
            end

            if (busy_o !== (block != 0)) begin
                err_cnt++;
                $display("ERROR %s: busy expected %b, actual %b",
                         test_name, (block != 0), busy_o);
            end

            // decision uses the model before this edge's updates
            if (ping_i && block == 0) begin
                exp_q.push_back(expected_pid(halt_m[ping_ep_i], free_m[ping_ep_i]));
                due_q.push_back(cyc + 4);
                block = 4;
            end else if (block > 0) begin
                block--;
            end

            if (halt_set_i) begin
                halt_m[halt_ep_i] = 1'b1;
            end else if (halt_clr_i) begin
                halt_m[halt_ep_i] = 1'b0;
            end
            if (wr_i) begin
                f = free_m[wr_ep_i] - int'(wr_len_i);
                free_m[wr_ep_i] = (f < 0) ? 0 : f;
            end
            if (drain_i) begin
                f = free_m[drain_ep_i] + int'(drain_len_i);
                free_m[drain_ep_i] = (f > 512) ? 512 : f;
            end
        end
    end

endmodule

// File: rtl/usb_ping_top.sv
// top level of the PING flow-control block connecting halt, space, FSM and encoder
module usb_ping_top
    import usb_ep_pkg::*;
    import usb_hs_pkg::*;
#(
    parameter int NUM_EP    = 16,
    parameter int BUF_BYTES = 512,
    parameter int MAX_PKT   = 512
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        ping_i,
    input  ep_num_t     ping_ep_i,
    input  logic        halt_set_i,
    input  logic        halt_clr_i,
    input  ep_num_t     halt_ep_i,
    input  logic        wr_i,
    input  ep_num_t     wr_ep_i,
    input  byte_cnt_t   wr_len_i,
    input  logic        drain_i,
    input  ep_num_t     drain_ep_i,
    input  byte_cnt_t   drain_len_i,
    output logic        hs_valid_o,
    output logic [7:0]  hs_pid_o,
    output logic        busy_o,
    output ping_state_e ping_state_o
);

    ep_num_t   lookup_ep;
    logic      ep_halted;
    byte_cnt_t ep_free;
    logic      hs_load;
    hs_kind_e  hs_kind;

    usb_ep_halt_regs #(
        .NUM_EP (NUM_EP)
    ) u_halt_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .halt_set_i  (halt_set_i),
        .halt_clr_i  (halt_clr_i),
        .halt_ep_i   (halt_ep_i),
        .lookup_ep_i (lookup_ep),
        .ep_halted_o (ep_halted)
    );

    usb_ep_space_counter #(
        .NUM_EP    (NUM_EP),
        .BUF_BYTES (BUF_BYTES)
    ) u_space_counter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_i        (wr_i),
        .wr_ep_i     (wr_ep_i),
        .wr_len_i    (wr_len_i),
        .drain_i     (drain_i),
        .drain_ep_i  (drain_ep_i),
        .drain_len_i (drain_len_i),
        .lookup_ep_i (lookup_ep),
        .ep_free_o   (ep_free)
    );

    usb_ping_fsm #(
        .MAX_PKT (MAX_PKT)
    ) u_ping_fsm (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ping_i       (ping_i),
        .ping_ep_i    (ping_ep_i),
        .ep_halted_i  (ep_halted),
        .ep_free_i    (ep_free),
        .lookup_ep_o  (lookup_ep),
        .hs_load_o    (hs_load),
        .hs_kind_o    (hs_kind),
        .busy_o       (busy_o),
        .ping_state_o (ping_state_o)
    );

    usb_hs_encoder u_hs_encoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .hs_load_i  (hs_load),
        .hs_kind_i  (hs_kind),
        .hs_valid_o (hs_valid_o),
        .hs_pid_o   (hs_pid_o)
    );

endmodule

// File: rtl/usb_hs_encoder.sv
// handshake encoder that registers the PID byte with a one-cycle valid pulse
module usb_hs_encoder
    import usb_hs_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       hs_load_i,
    input  hs_kind_e   hs_kind_i,
    output logic       hs_valid_o,
    output logic [7:0] hs_pid_o
);

    logic [7:0] pid_d;
    logic       send;

    always_comb begin
        case (hs_kind_i)
            HS_ACK:   pid_d = PID_ACK;
            HS_NAK:   pid_d = PID_NAK;
            HS_STALL: pid_d = PID_STALL;
            default:  pid_d = hs_pid_o;
        endcase
    end

    // a load with no decided kind sends nothing
    assign send = hs_load_i && (hs_kind_i != HS_NONE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hs_valid_o <= 1'b0;
            hs_pid_o   <= 8'h00;
        end else begin
            hs_valid_o <= send;
            // pid holds between responses
            if (send) begin
                hs_pid_o <= pid_d;
            end
        end
    end

endmodule

// File: rtl/usb_ping_fsm.sv
// PING FSM that snapshots endpoint status on acceptance and decides the handshake
module usb_ping_fsm
    import usb_ep_pkg::*;
    import usb_hs_pkg::*;
#(
    parameter int MAX_PKT = 512
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        ping_i,
    input  ep_num_t     ping_ep_i,
    input  logic        ep_halted_i,
    input  byte_cnt_t   ep_free_i,
    output ep_num_t     lookup_ep_o,
    output logic        hs_load_o,
    output hs_kind_e    hs_kind_o,
    output logic        busy_o,
    output ping_state_e ping_state_o
);

    localparam byte_cnt_t MAX_PKT_CNT = byte_cnt_t'(MAX_PKT);

    ping_state_e state_d;
    hs_kind_e    kind_d;
    logic        load_d;
    logic        accept;

    // snapshot taken on the accepting edge
    ep_num_t     ep_q;
    logic        halted_q;
    byte_cnt_t   free_q;
    logic        room_q;

    assign accept = (ping_state_o == IDLE) && ping_i;

    // follow the incoming ping while idle so the read sees pre-edge status
    assign lookup_ep_o = (ping_state_o == IDLE) ? ping_ep_i : ep_q;

    always_comb begin
        state_d = ping_state_o;
        kind_d  = hs_kind_o;
        load_d  = 1'b0;

        case (ping_state_o)
            IDLE: begin
                kind_d = HS_NONE;
                if (ping_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = DECIDE;
            end
            DECIDE: begin
                if (halted_q) begin
                    kind_d = HS_STALL;
                end else if (room_q) begin
                    kind_d = HS_ACK;
                end else begin
                    kind_d = HS_NAK;
                end
                load_d  = 1'b1;
                state_d = RESPOND;
            end
            RESPOND: begin
                state_d = COMPLETE;
            end
            COMPLETE: begin
                kind_d  = HS_NONE;
                state_d = IDLE;
            end
            default: begin
                kind_d  = HS_NONE;
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ping_state_o <= IDLE;
            hs_kind_o    <= HS_NONE;
            hs_load_o    <= 1'b0;
            busy_o       <= 1'b0;
            ep_q         <= '0;
            halted_q     <= 1'b0;
            free_q       <= '0;
            room_q       <= 1'b0;
        end else begin
            ping_state_o <= state_d;
            hs_kind_o    <= kind_d;
            hs_load_o    <= load_d;
            busy_o       <= (state_d != IDLE);

            if (accept) begin
                ep_q     <= ping_ep_i;
                halted_q <= ep_halted_i;
                free_q   <= ep_free_i;
            end

            // room compare registered one stage ahead of the decision
            if (ping_state_o == LOOKUP) begin
                room_q <= (free_q >= MAX_PKT_CNT);
            end
        end
    end

endmodule

// File: rtl/usb_ep_space_counter.sv
// per-endpoint saturating free-byte counters with a combinational read port
module usb_ep_space_counter
    import usb_ep_pkg::*;
#(
    parameter int NUM_EP    = 16,
    parameter int BUF_BYTES = 512
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      wr_i,
    input  ep_num_t   wr_ep_i,
    input  byte_cnt_t wr_len_i,
    input  logic      drain_i,
    input  ep_num_t   drain_ep_i,
    input  byte_cnt_t drain_len_i,
    input  ep_num_t   lookup_ep_i,
    output byte_cnt_t ep_free_o
);

    localparam byte_cnt_t BUF_CNT = byte_cnt_t'(BUF_BYTES);

    byte_cnt_t free_q [NUM_EP];
    byte_cnt_t free_d [NUM_EP];

    function automatic byte_cnt_t sat_sub(byte_cnt_t a, byte_cnt_t b);
        return (a > b) ? byte_cnt_t'(a - b) : '0;
    endfunction

    // room left below the buffer size bounds the add, so no overflow
    function automatic byte_cnt_t sat_add(byte_cnt_t a, byte_cnt_t b);
        return (b >= byte_cnt_t'(BUF_CNT - a)) ? BUF_CNT : byte_cnt_t'(a + b);
    endfunction

    // write applied before drain when both hit one endpoint
    always_comb begin
        for (int i = 0; i < NUM_EP; i++) begin
            free_d[i] = free_q[i];
            if (wr_i && wr_ep_i == ep_num_t'(i)) begin
                free_d[i] = sat_sub(free_d[i], wr_len_i);
            end
            if (drain_i && drain_ep_i == ep_num_t'(i)) begin
                free_d[i] = sat_add(free_d[i], drain_len_i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_EP; i++) begin
                free_q[i] <= BUF_CNT;
            end
        end else begin
            for (int i = 0; i < NUM_EP; i++) begin
                free_q[i] <= free_d[i];
            end
        end
    end

    // out of range endpoints report no room
    always_comb begin
        ep_free_o = '0;
        for (int i = 0; i < NUM_EP; i++) begin
            if (lookup_ep_i == ep_num_t'(i)) begin
                ep_free_o = free_q[i];
            end
        end
    end

endmodule

// File: rtl/usb_ep_halt_regs.sv
// per-endpoint halt bits with set and clear strobes and a combinational read port
module usb_ep_halt_regs
    import usb_ep_pkg::*;
#(
    parameter int NUM_EP = 16
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    halt_set_i,
    input  logic    halt_clr_i,
    input  ep_num_t halt_ep_i,
    input  ep_num_t lookup_ep_i,
    output logic    ep_halted_o
);

    logic [NUM_EP-1:0] halt_q;

    // set wins when both strobes hit the same endpoint
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            halt_q <= '0;
        end else begin
            for (int i = 0; i < NUM_EP; i++) begin
                if (halt_ep_i == ep_num_t'(i)) begin
                    if (halt_set_i) begin
                        halt_q[i] <= 1'b1;
                    end else if (halt_clr_i) begin
                        halt_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // missing endpoints look halted so a ping there gets STALL
    always_comb begin
        ep_halted_o = 1'b1;
        for (int i = 0; i < NUM_EP; i++) begin
            if (lookup_ep_i == ep_num_t'(i)) begin
                ep_halted_o = halt_q[i];
            end
        end
    end

endmodule

// File: rtl/usb_hs_pkg.sv
// handshake kinds, handshake PID bytes and PING FSM state encoding
package usb_hs_pkg;

    // answer decided for a ping
    typedef enum logic [1:0] {
        HS_NONE  = 2'd0,
        HS_ACK   = 2'd1,
        HS_NAK   = 2'd2,
        HS_STALL = 2'd3
    } hs_kind_e;

    // full pid bytes, check nibble in the upper half
    localparam logic [7:0] PID_ACK   = 8'hD2;
    localparam logic [7:0] PID_NAK   = 8'h5A;
    localparam logic [7:0] PID_STALL = 8'h1E;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        LOOKUP   = 3'd1,
        DECIDE   = 3'd2,
        RESPOND  = 3'd3,
        COMPLETE = 3'd4
    } ping_state_e;

endpackage

// File: rtl/usb_ep_pkg.sv
// endpoint number and byte count types shared by the endpoint-side blocks
package usb_ep_pkg;

    // endpoint field width from the usb token format
    localparam int EP_ADDR_W = 4;

    // wide enough for a 1024 byte buffer
    localparam int BYTE_CNT_W = 11;

    typedef logic [EP_ADDR_W-1:0] ep_num_t;

    // free space, write length and drain length
    typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

endpackage
